//--- include/rv_core_config.svh
/*
 * Core-wide sizes for the fetch, queue and execute blocks.
 * Included by the package and by any module that needs a raw width.
 */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// instruction queue entries
`define IQ_DEPTH 4

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- src/rv_core_pkg.sv
/*
 * Shared types for the core: words, register indices and the enums
 * used by decode, the ALU and the fetch FSM. Import with rv_core_pkg::*.
 */
`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // rom request sequencer
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA
    } fetch_state_e;

endpackage

`default_nettype wire

//--- src/inst_fetch.sv
/*
 * Instruction fetch: holds the PC and walks the ROM through the
 * request / address-ok / data-ok / data-resp strobes, one fetch at a time.
 * Each returned word is pushed into the instruction queue with its PC.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module inst_fetch import rv_core_pkg::*; (
    input  wire   clk_i,
    input  wire   arst_n_i,
    input  wire   iq_full_i,
    output logic  rom_req_o,
    output word_t rom_address_o,
    input  wire   rom_addr_ok_i,
    input  wire   rom_data_ok_i,
    input  word_t rom_rdata_i,
    output logic  rom_data_resp_o,
    output logic  push_o,
    output word_t push_pc_o,
    output word_t push_inst_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    word_t        pc_q;
    logic         data_take;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                // hold off while the queue has no free slot
                if (!iq_full_i) begin
                    state_d = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                if (rom_addr_ok_i) begin
                    state_d = FETCH_DATA;
                end
            end
            FETCH_DATA: begin
                if (rom_data_ok_i) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= `RESET_PC;
        end else begin
            state_q <= state_d;
            // no branches, so the pc only steps forward
            if (data_take) begin
                pc_q <= pc_q + word_t'(4);
            end
        end
    end

    //////////////////////////////////////////////////
    // rom strobes and queue push
    //////////////////////////////////////////////////

    assign data_take       = (state_q == FETCH_DATA) && rom_data_ok_i;

    // address is held stable until the rom accepts it
    assign rom_req_o       = (state_q == FETCH_ADDR);
    assign rom_address_o   = pc_q;
    assign rom_data_resp_o = data_take;

    assign push_o      = data_take;
    assign push_pc_o   = pc_q;
    assign push_inst_o = rom_rdata_i;

endmodule

`default_nettype wire

//--- src/inst_queue.sv
/*
 * First-word-fall-through queue of (pc, instruction) pairs between
 * fetch and execute. The head is visible combinationally.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module inst_queue import rv_core_pkg::*; #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  wire   clk_i,
    input  wire   arst_n_i,
    input  wire   push_i,
    input  word_t push_pc_i,
    input  word_t push_inst_i,
    input  wire   pop_i,
    output logic  full_o,
    output logic  valid_o,
    output word_t head_pc_o,
    output word_t head_inst_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t             pc_mem   [DEPTH];
    word_t             inst_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    // payload storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]   <= push_pc_i;
            inst_mem[wr_ptr_q] <= push_inst_i;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_pc_o   = pc_mem[rd_ptr_q];
    assign head_inst_o = inst_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- src/regfile.sv
/*
 * 32-entry integer register file, x0 hardwired to zero.
 * Two execute read ports and one debug read port, all combinational.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module regfile import rv_core_pkg::*; (
    input  wire       clk_i,
    input  wire       arst_n_i,
    input  wire       we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    // no storage behind x0
    word_t regs [1:NUM_REGS-1];

    function automatic word_t read_reg(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o   = read_reg(raddr1_i);
    assign rdata2_o   = read_reg(raddr2_i);
    assign dbg_data_o = read_reg(dbg_addr_i);

endmodule

`default_nettype wire

//--- src/exec_unit.sv
/*
 * Execute stage: pops the queue head, decodes it, runs the ALU and
 * writes rd in the same cycle. Halt blocks the pop; the regfile debug
 * read port is passed through to the top.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module exec_unit import rv_core_pkg::*; (
    input  wire       clk_i,
    input  wire       arst_n_i,
    input  wire       valid_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  wire       halt_i,
    output logic      pop_o,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o
);

    opcode_e   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t     imm_i;
    word_t     imm_u;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_res;
    word_t     wb_data;
    alu_op_e   alu_op;
    logic      supported;
    logic      reg_we;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{(`XLEN - 12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {inst_i[31:12], 12'b0};

    always_comb begin
        case (funct3)
            // sub only exists in the register form
            3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        // auipc and lui only need an add
        if (opcode == OPC_AUIPC || opcode == OPC_LUI) begin
            alu_op = ALU_ADD;
        end
    end

    assign supported = (opcode == OPC_OP_IMM) || (opcode == OPC_OP) ||
                       (opcode == OPC_LUI) || (opcode == OPC_AUIPC);

    //////////////////////////////////////////////////
    // operands and alu
    //////////////////////////////////////////////////

    assign op_a = (opcode == OPC_AUIPC) ? pc_i : rs1_data;
    assign op_b = (opcode == OPC_OP) ? rs2_data :
                  (opcode == OPC_OP_IMM) ? imm_i : imm_u;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {{(`XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`XLEN - 1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // lui skips the rs1 path, its bits there are immediate
    assign wb_data = (opcode == OPC_LUI) ? imm_u : alu_res;

    assign pop_o  = valid_i && !halt_i;
    assign reg_we = pop_o && supported && (rd != '0);

    regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .we_i       (reg_we),
        .waddr_i    (rd),
        .wdata_i    (wb_data),
        .raddr1_i   (rs1),
        .raddr2_i   (rs2),
        .rdata1_o   (rs1_data),
        .rdata2_o   (rs2_data),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

endmodule

`default_nettype wire

//--- src/rv_core.sv
/*
 * Core top level: fetch feeds the instruction queue, execute drains it.
 * ROM strobes and the debug halt / register read go to the outside.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  wire       clk_i,
    input  wire       arst_n_i,
    output logic      rom_req_o,
    output word_t     rom_address_o,
    input  wire       rom_addr_ok_i,
    input  wire       rom_data_ok_i,
    input  word_t     rom_rdata_i,
    output logic      rom_data_resp_o,
    input  wire       jtag_halt_flag_i,
    input  reg_addr_t jtag_reg_addr_i,
    output word_t     jtag_reg_data_o
);

    // fetch to queue
    logic  iq_push;
    word_t iq_push_pc;
    word_t iq_push_inst;
    logic  iq_full;

    // queue to execute
    logic  iq_valid;
    logic  iq_pop;
    word_t iq_head_pc;
    word_t iq_head_inst;

    inst_fetch u_inst_fetch (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .iq_full_i       (iq_full),
        .rom_req_o       (rom_req_o),
        .rom_address_o   (rom_address_o),
        .rom_addr_ok_i   (rom_addr_ok_i),
        .rom_data_ok_i   (rom_data_ok_i),
        .rom_rdata_i     (rom_rdata_i),
        .rom_data_resp_o (rom_data_resp_o),
        .push_o          (iq_push),
        .push_pc_o       (iq_push_pc),
        .push_inst_o     (iq_push_inst)
    );

    inst_queue u_inst_queue (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (iq_push),
        .push_pc_i   (iq_push_pc),
        .push_inst_i (iq_push_inst),
        .pop_i       (iq_pop),
        .full_o      (iq_full),
        .valid_o     (iq_valid),
        .head_pc_o   (iq_head_pc),
        .head_inst_o (iq_head_inst)
    );

    exec_unit u_exec_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .valid_i    (iq_valid),
        .pc_i       (iq_head_pc),
        .inst_i     (iq_head_inst),
        .halt_i     (jtag_halt_flag_i),
        .pop_o      (iq_pop),
        .dbg_addr_i (jtag_reg_addr_i),
        .dbg_data_o (jtag_reg_data_o)
    );

endmodule

`default_nettype wire

//--- tests/rv_core_properties.sv
/*
 * Concurrent checks on the fetch ROM strobes and on queue occupancy.
 * Bound into rv_core so that it sees the fetch FSM and the queue count.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_properties import rv_core_pkg::*; #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         rom_req_i,
    input  wire                         rom_addr_ok_i,
    input  wire                         rom_data_resp_i,
    input  fetch_state_e                fetch_state_i,
    input  wire [$clog2(DEPTH + 1)-1:0] iq_count_i
);

    // request is held until the rom accepts the address
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rom_req_i && !rom_addr_ok_i |=> rom_req_i)
        else $error("rom_req_o dropped before rom_addr_ok_i");

    // data response only in the data phase of an accepted address
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rom_data_resp_i |-> fetch_state_i == FETCH_DATA &&
            ($past(rom_req_i && rom_addr_ok_i) || $past(fetch_state_i) == FETCH_DATA))
        else $error("rom_data_resp_o high outside the data phase of an accepted address");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        iq_count_i <= DEPTH)
        else $error("instruction queue count above its depth");

endmodule

bind rv_core rv_core_properties #(.DEPTH(`IQ_DEPTH)) u_rv_core_properties (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .rom_req_i       (rom_req_o),
    .rom_addr_ok_i   (rom_addr_ok_i),
    .rom_data_resp_i (rom_data_resp_o),
    .fetch_state_i   (u_inst_fetch.state_q),
    .iq_count_i      (u_inst_queue.count_q)
);

`default_nettype wire

//--- tests/rv_core_tb.sv
/*
 * Testbench for rv_core: a ROM with random strobe delays serves a random
 * RV32I program, a reference model predicts the register file, and the
 * debug port reads it back after a halt with back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int PROG_LEN    = 40;
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = PROG_LEN * (1 + 3 + 3 + 1) * CLK_NS + 2000;

    logic      clk_i;
    logic      arst_n_i;
    logic      rom_req_o;
    word_t     rom_address_o;
    logic      rom_addr_ok_i;
    logic      rom_data_ok_i;
    word_t     rom_rdata_i;
    logic      rom_data_resp_o;
    logic      jtag_halt_flag_i;
    reg_addr_t jtag_reg_addr_i;
    word_t     jtag_reg_data_o;

    integer seed = 92;
    word_t  prog [$];
    word_t  model_regs [32];
    word_t  exp_addr;
    int     accepted_cnt;
    int     pushed_cnt;
    int     check_cnt;
    int     mismatch_cnt;
    int     error_cnt;

    rv_core u_rv_core (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .rom_req_o        (rom_req_o),
        .rom_address_o    (rom_address_o),
        .rom_addr_ok_i    (rom_addr_ok_i),
        .rom_data_ok_i    (rom_data_ok_i),
        .rom_rdata_i      (rom_rdata_i),
        .rom_data_resp_o  (rom_data_resp_o),
        .jtag_halt_flag_i (jtag_halt_flag_i),
        .jtag_reg_addr_i  (jtag_reg_addr_i),
        .jtag_reg_data_o  (jtag_reg_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_NS / 2) clk_i = ~clk_i;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks and helpers
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t rom_address_o got=%08h exp=%08h", $time, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        error_cnt++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // one debug read per cycle, sampled mid-cycle
    task automatic read_reg(input int idx, output word_t val);
        @(posedge clk_i);
        #1;
        jtag_reg_addr_i = reg_addr_t'(idx);
        @(negedge clk_i);
        val = jtag_reg_data_o;
    endtask

    task automatic wait_pushes(input int n);
        while (pushed_cnt < n) begin
            @(negedge clk_i);
        end
    endtask

    function automatic word_t rom_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= 0 && idx < prog.size()) begin
            return prog[idx];
        end
        // everything past the program is the all-zero word
        return '0;
    endfunction

    //////////////////////////////////////////////////
    // program generation and reference model
    //////////////////////////////////////////////////

    function automatic word_t gen_inst(input int idx);
        word_t      r;
        word_t      w;
        int         kind;
        logic [6:0] f7;
        logic [2:0] f3;
        r    = $random(seed);
        kind = {$random(seed)} % 9;
        f3   = r[14:12];
        f7   = r[30] ? 7'b0100000 : 7'b0000000;
        if (idx % 13 == 6) begin
            // load and branch words, not executed by this core
            w = {r[31:7], (idx == 19) ? 7'b1100011 : 7'b0000011};
        end else if (kind < 4) begin
            if (f3 == 3'b001) begin
                w = {7'b0000000, r[24:15], f3, r[11:7], OPC_OP_IMM};
            end else if (f3 == 3'b101) begin
                w = {f7, r[24:15], f3, r[11:7], OPC_OP_IMM};
            end else begin
                w = {r[31:7], OPC_OP_IMM};
            end
        end else if (kind < 7) begin
            if (f3 != 3'b000 && f3 != 3'b101) begin
                f7 = 7'b0000000;
            end
            w = {f7, r[24:15], f3, r[11:7], OPC_OP};
        end else if (kind == 7) begin
            w = {r[31:7], OPC_LUI};
        end else begin
            w = {r[31:7], OPC_AUIPC};
        end
        if (idx == 10) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    function automatic void ref_execute(input word_t inst, input word_t pc);
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      imm;
        logic [4:0] rd;
        logic       write;
        rd    = inst[11:7];
        a     = model_regs[inst[19:15]];
        imm   = {{20{inst[31]}}, inst[31:20]};
        res   = '0;
        write = 1'b1;
        case (inst[6:0])
            OPC_LUI:   res = {inst[31:12], 12'h000};
            OPC_AUIPC: res = pc + {inst[31:12], 12'h000};
            OPC_OP_IMM, OPC_OP: begin
                b = (inst[6:0] == OPC_OP) ? model_regs[inst[24:20]] : imm;
                case (inst[14:12])
                    3'b000:  res = (inst[6:0] == OPC_OP && inst[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b101:  res = inst[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            default: write = 1'b0;
        endcase
        if (write && rd != 5'd0) begin
            model_regs[rd] = res;
        end
    endfunction

    //////////////////////////////////////////////////
    // rom model
    //////////////////////////////////////////////////

    initial begin : rom_model
        int    d;
        word_t addr;
        rom_addr_ok_i = 1'b0;
        rom_data_ok_i = 1'b0;
        rom_rdata_i   = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rom_req_o) begin
                d = {$random(seed)} % 4;
                repeat (d) begin
                    @(posedge clk_i);
                    #1;
                end
                addr          = rom_address_o;
                rom_addr_ok_i = 1'b1;
                check_addr(addr, exp_addr);
                exp_addr      = exp_addr + 32'd4;
                accepted_cnt++;
                @(posedge clk_i);
                #1;
                rom_addr_ok_i = 1'b0;
                d = 1 + {$random(seed)} % 3;
                repeat (d - 1) begin
                    @(posedge clk_i);
                    #1;
                end
                rom_data_ok_i = 1'b1;
                rom_rdata_i   = rom_word(addr);
                @(negedge clk_i);
                if (!rom_data_resp_o) begin
                    flag_error("rom_data_resp_o stayed low while rom_data_ok_i was high");
                end
                @(posedge clk_i);
                #1;
                rom_data_ok_i = 1'b0;
                rom_rdata_i   = '0;
                pushed_cnt++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR t=%0t watchdog expired before the test sequence finished", $time);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence and compare
    //////////////////////////////////////////////////

    initial begin : main_seq
        word_t val;
        int    accepted_at_halt;
        arst_n_i         = 1'b0;
        jtag_halt_flag_i = 1'b0;
        jtag_reg_addr_i  = '0;
        exp_addr         = `RESET_PC;
        accepted_cnt     = 0;
        pushed_cnt       = 0;
        check_cnt        = 0;
        mismatch_cnt     = 0;
        error_cnt        = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog.push_back(gen_inst(i));
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // model state at the halt point, the second half runs after release
        for (int i = 0; i < PROG_LEN / 2; i++) begin
            ref_execute(prog[i], word_t'(i * 4));
        end

        repeat (2) @(posedge clk_i);
        #1;
        if (rom_req_o || rom_data_resp_o) begin
            flag_error("ROM strobes active while reset is asserted");
        end
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #1;
        if (!rom_req_o) begin
            flag_error("rom_req_o did not rise in the first cycle after reset");
        end

        // halt halfway, queue fills up and fetch has to stop
        // the last pushed word pops at the edge before halt rises
        wait_pushes(PROG_LEN / 2);
        accepted_at_halt = accepted_cnt;
        @(posedge clk_i);
        #1;
        jtag_halt_flag_i = 1'b1;
        for (int i = 0; i < 32; i++) begin
            read_reg(i, val);
            check_word($sformatf("x%0d at halt", i), val, model_regs[i]);
        end
        repeat (8) @(posedge clk_i);
        for (int i = 0; i < 32; i++) begin
            read_reg(i, val);
            check_word($sformatf("x%0d during halt", i), val, model_regs[i]);
        end
        if (accepted_cnt - accepted_at_halt > `IQ_DEPTH) begin
            flag_error("fetch accepted more addresses than the queue can hold during halt");
        end
        @(posedge clk_i);
        #1;
        jtag_halt_flag_i = 1'b0;
        for (int i = PROG_LEN / 2; i < PROG_LEN; i++) begin
            ref_execute(prog[i], word_t'(i * 4));
        end

        // enough pushes that the last program word has left the queue
        wait_pushes(PROG_LEN + `IQ_DEPTH);
        repeat (4) @(posedge clk_i);
        #1;
        jtag_halt_flag_i = 1'b1;
        for (int i = 0; i < 32; i++) begin
            read_reg(i, val);
            check_word($sformatf("x%0d", i), val, model_regs[i]);
        end

        $display("checks=%0d mismatches=%0d other_errors=%0d",
                 check_cnt, mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
src/rv_core_pkg.sv
src/inst_fetch.sv
src/inst_queue.sv
src/regfile.sv
src/exec_unit.sv
src/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the rv_core testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f filelist.f --top-module rv_core_tb \
    && ./obj_dir/Vrv_core_tb | tee sim.log \
    || { echo "build or run of rv_core_tb failed"; exit 1; }

grep -qx "Result: PASSED" sim.log && echo "simulation ok" \
    || { echo "pass line not found in sim.log"; exit 1; }
